/* tb.f */
verilog/scaler_geom_pkg.sv
verilog/cubic_pkg.sv
verilog/frac_table.sv
verilog/cubic_weight_gen.sv
verilog/scale_sequencer.sv
verilog/cubic_tap.sv
verilog/tap_sum_clamp.sv
verilog/bicubic_scaler.sv
sim/scaler_properties.sv
sim/scaler_checker.sv
sim/tb_bicubic.sv

/* run_sim.sh */
#!/bin/sh
# build and run the bicubic scaler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_bicubic \
    -f tb.f -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* sim/tb_bicubic.sv */
module tb_bicubic
    import scaler_geom_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DONE_LIMIT = 5000;   // cycles per configuration

    logic               CLK = 1'b0;
    logic               RST = 1'b1;
    logic [COORD_W-1:0] v0 = '0;
    logic [COORD_W-1:0] h0 = '0;
    logic [SW_W-1:0]    sw = '0;
    logic [SW_W-1:0]    sh = '0;
    logic [TW_W-1:0]    tw = '0;
    logic [PIX_W-1:0]   pix_data = '0;
    logic               pix_rd;
    logic [ADDR_W-1:0]  pix_addr;
    logic               res_we;
    logic [ADDR_W-1:0]  res_addr;
    logic [PIX_W-1:0]   res_data;
    logic               done;
    logic [PIX_W-1:0]   image [IMG_DIM][IMG_DIM];
    int                 seed = 99421;
    int                 test_id = 0;
    logic               expect_clamp = 1'b0;
    int                 error_count;
    int                 write_total;
    int                 timeout_count = 0;
    logic               rd_pending;
    logic [ADDR_W-1:0]  rd_addr;

    always #4 CLK = ~CLK;

    bicubic_scaler u_dut (
        .CLK(CLK), .RST(RST),
        .v0_i(v0), .h0_i(h0), .sw_i(sw), .sh_i(sh), .tw_i(tw),
        .pix_data_i(pix_data), .pix_rd_o(pix_rd), .pix_addr_o(pix_addr),
        .res_we_o(res_we), .res_addr_o(res_addr), .res_data_o(res_data),
        .done_o(done)
    );

    scaler_checker u_checker (
        .CLK(CLK), .RST(RST), .test_id_i(test_id), .expect_clamp_i(expect_clamp),
        .v0_i(v0), .h0_i(h0), .sw_i(sw), .sh_i(sh), .tw_i(tw), .img_i(image),
        .res_we_i(res_we), .res_addr_i(res_addr), .res_data_i(res_data), .done_i(done),
        .error_count_o(error_count), .write_total_o(write_total)
    );

    bind bicubic_scaler scaler_properties u_props (
        .CLK(CLK), .RST(RST), .v0_i(v0_i), .h0_i(h0_i), .sw_i(sw_i), .sh_i(sh_i),
        .pix_rd_i(pix_rd_o), .pix_addr_i(pix_addr_o), .res_we_i(res_we_o), .done_i(done_o)
    );

    // image memory returns data one cycle after the read
    always @(posedge CLK) begin
        rd_pending = pix_rd;
        rd_addr    = pix_addr;
        #1;
        if (rd_pending) pix_data = image[rd_addr / IMG_DIM][rd_addr % IMG_DIM];
    end

    task automatic fill_random();
        for (int r = 0; r < IMG_DIM; r++) begin
            for (int c = 0; c < IMG_DIM; c++) begin
                image[r][c] = PIX_W'($random(seed));
            end
        end
    endtask

    task automatic fill_step();
        for (int r = 0; r < IMG_DIM; r++) begin
            for (int c = 0; c < IMG_DIM; c++) begin
                image[r][c] = (c >= 40 + r % 3) ? 8'd255 : 8'd0;   // edge moves per row
            end
        end
    endtask

    task automatic wait_for_done(input int limit);
        int cycles;
        cycles = 0;
        while (!done && cycles < limit) begin
            @(posedge CLK);
            #1;
            cycles++;
        end
        if (!done) begin
            $display("timeout: done_o did not rise within %0d cycles in configuration %0d",
                     limit, test_id);
            timeout_count++;
        end
    endtask

    task automatic observe_after_done(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic run_config(input int id, input int row0, input int col0, input int src_w,
                              input int src_h, input int dst_w, input logic clamp_exp);
        @(posedge CLK);
        #1;
        RST          = 1'b1;
        test_id      = id;
        expect_clamp = clamp_exp;
        v0 = COORD_W'(row0);
        h0 = COORD_W'(col0);
        sw = SW_W'(src_w);
        sh = SW_W'(src_h);
        tw = TW_W'(dst_w);
        repeat (8) @(posedge CLK);
        #1;
        RST = 1'b0;
        wait_for_done(DONE_LIMIT);
        if (timeout_count == 0) begin
            observe_after_done(6);  // late writes or a falling done show up here
        end
    endtask

    initial begin
        fill_random();
        run_config(0, 10, 20, 17, 6, 17, 1'b0);
        if (timeout_count == 0) begin
            fill_random();
            run_config(1, 50, 60, 17, 5, 22, 1'b0);
        end
        if (timeout_count == 0) begin
            fill_step();
            run_config(2, 90, 38, 5, 4, 31, 1'b1);
        end
        $display("summary: %0d result writes checked, %0d errors, %0d timeouts",
                 write_total, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* sim/scaler_checker.sv */
module scaler_checker
    import scaler_geom_pkg::*;
(
    input  logic               CLK,
    input  logic               RST,
    input  int                 test_id_i,
    input  logic               expect_clamp_i,
    input  logic [COORD_W-1:0] v0_i,
    input  logic [COORD_W-1:0] h0_i,
    input  logic [SW_W-1:0]    sw_i,
    input  logic [SW_W-1:0]    sh_i,
    input  logic [TW_W-1:0]    tw_i,
    input  logic [PIX_W-1:0]   img_i [IMG_DIM][IMG_DIM],
    input  logic               res_we_i,
    input  logic [ADDR_W-1:0]  res_addr_i,
    input  logic [PIX_W-1:0]   res_data_i,
    input  logic               done_i,
    output int                 error_count_o,
    output int                 write_total_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int   err_cnt = 0;
    int   wr_total = 0;
    int   wr_count;
    int   clamp_count;
    int   total;
    logic done_q;
    logic written [1 << ADDR_W];

    assign error_count_o = err_cnt;
    assign write_total_o = wr_total;

    function automatic string test_name(input int id);
        case (id)
            0:       return "identity_17_to_17";
            1:       return "upscale_17_to_22";
            default: return "step_5_to_31";
        endcase
    endfunction

    // rounded, shifted sum before clamping
    function automatic int bicubic_raw(input int row, input int col);
        int num;
        int den;
        int q;
        int t;
        int t2;
        int t3;
        int w [4];
        int acc;
        num = col * (int'(sw_i) - 1);
        den = int'(tw_i) - 1;
        q   = num / den;
        t   = ((num % den) * 256) / den;
        t2  = (t * t + 128) >> 8;
        t3  = (t2 * t + 128) >> 8;
        w[0] = -t + 2 * t2 - t3;
        w[1] = 512 - 5 * t2 + 3 * t3;
        w[2] = t + 4 * t2 - 3 * t3;
        w[3] = -t2 + t3;
        acc = 256;
        for (int k = 0; k < 4; k++) begin
            acc += int'(img_i[int'(v0_i) + row][int'(h0_i) + q - 1 + k]) * w[k];
        end
        return acc >>> 9;
    endfunction

    function automatic int clamp_pixel(input int v);
        if (v < 0) return 0;
        if (v > 255) return 255;
        return v;
    endfunction

    task automatic report_mismatch(input string what, input int expected, input int actual);
        $display("[FAIL] %s: %s expected %0d, got %0d", test_name(test_id_i), what,
                 expected, actual);
        err_cnt++;
    endtask

    task automatic report_error(input string msg);
        $display("%s: %s", test_name(test_id_i), msg);
        err_cnt++;
    endtask

    task automatic check_write();
        int exp_addr;
        int row;
        int col;
        int raw;
        exp_addr = (wr_count / int'(tw_i)) * ROW_PITCH + wr_count % int'(tw_i);
        row = int'(res_addr_i) / ROW_PITCH;
        col = int'(res_addr_i) % ROW_PITCH;
        if (done_i) report_error("result written after done_o rose");
        if (wr_count >= total) begin
            report_error($sformatf("more than %0d result writes", total));
        end else if (int'(res_addr_i) != exp_addr) begin
            report_mismatch($sformatf("address of write %0d", wr_count), exp_addr, res_addr_i);
        end
        if (written[res_addr_i]) report_error($sformatf("address %0d written twice", res_addr_i));
        written[res_addr_i] = 1'b1;
        if (row >= int'(sh_i) || col >= int'(tw_i)) begin
            report_error($sformatf("address %0d outside the output window", res_addr_i));
        end else begin
            raw = bicubic_raw(row, col);
            // overshoot that came out pinned at the bound
            if ((raw < 0 || raw > 255) && int'(res_data_i) == clamp_pixel(raw)) begin
                clamp_count++;
            end
            if (int'(res_data_i) != clamp_pixel(raw)) begin
                report_mismatch($sformatf("pixel (%0d,%0d)", row, col), clamp_pixel(raw),
                                res_data_i);
            end
            if (int'(sw_i) == int'(tw_i)
                && res_data_i != img_i[int'(v0_i) + row][int'(h0_i) + col]) begin
                report_mismatch($sformatf("copy of (%0d,%0d)", row, col),
                                img_i[int'(v0_i) + row][int'(h0_i) + col], res_data_i);
            end
        end
        wr_count++;
        wr_total++;
    endtask

    always @(posedge CLK) begin
        if (RST) begin
            wr_count    = 0;
            clamp_count = 0;
            done_q      = 1'b0;
            for (int a = 0; a < (1 << ADDR_W); a++) begin
                written[a] = 1'b0;
            end
        end else begin
            total = int'(tw_i) * int'(sh_i);
            if (res_we_i) check_write();
            if (done_i && !done_q) begin
                if (wr_count != total) begin
                    report_error($sformatf("done_o rose after %0d of %0d writes", wr_count, total));
                end
                if (expect_clamp_i && clamp_count == 0) begin
                    report_error("no overshooting result was clamped on the step image");
                end
            end
            if (done_q && !done_i) report_error("done_o fell before reset");
            done_q = done_i;
        end
    end

endmodule

/* sim/scaler_properties.sv */
module scaler_properties
    import scaler_geom_pkg::*;
(
    input  logic               CLK,
    input  logic               RST,
    input  logic [COORD_W-1:0] v0_i,
    input  logic [COORD_W-1:0] h0_i,
    input  logic [SW_W-1:0]    sw_i,
    input  logic [SW_W-1:0]    sh_i,
    input  logic               pix_rd_i,
    input  logic [ADDR_W-1:0]  pix_addr_i,
    input  logic               res_we_i,
    input  logic               done_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int rd_row;
    int rd_col;

    assign rd_row = int'(pix_addr_i) / IMG_DIM;
    assign rd_col = int'(pix_addr_i) % IMG_DIM;

    a_reset_quiet: assert property (@(posedge CLK) RST |=> (!pix_rd_i && !res_we_i && !done_i))
        else $error("read, write or done active in the cycle after reset");

    a_no_write_after_done: assert property (@(posedge CLK) disable iff (RST)
        done_i |-> !res_we_i)
        else $error("result write while done is high");

    // taps span h0-1 .. h0+sw+1 on rows v0 .. v0+sh-1
    a_read_in_window: assert property (@(posedge CLK) disable iff (RST)
        pix_rd_i |-> ((rd_row >= int'(v0_i)) && (rd_row < int'(v0_i) + int'(sh_i))
                      && (rd_col >= int'(h0_i) - 1) && (rd_col <= int'(h0_i) + int'(sw_i) + 1)))
        else $error("pixel read outside the tap window");

endmodule

/* verilog/bicubic_scaler.sv */
module bicubic_scaler
    import scaler_geom_pkg::*;
    import cubic_pkg::*;
(
    input  logic               CLK,
    input  logic               RST,
    input  logic [COORD_W-1:0] v0_i,
    input  logic [COORD_W-1:0] h0_i,
    input  logic [SW_W-1:0]    sw_i,
    input  logic [SW_W-1:0]    sh_i,
    input  logic [TW_W-1:0]    tw_i,
    input  logic [PIX_W-1:0]   pix_data_i,
    output logic               pix_rd_o,
    output logic [ADDR_W-1:0]  pix_addr_o,
    output logic               res_we_o,
    output logic [ADDR_W-1:0]  res_addr_o,
    output logic [PIX_W-1:0]   res_data_o,
    output logic               done_o
);

    logic                       build_start;
    logic                       build_done;
    logic [COORD_W-1:0]         frac_idx;
    logic [FRAC_W-1:0]          frac_val;
    logic                       wload;
    logic signed [WEIGHT_W-1:0] weight [NUM_TAPS];
    logic signed [PROD_W-1:0]   prod [NUM_TAPS];
    logic [1:0]                 tap_sel;
    logic                       pix_valid;
    logic                       prod_go;
    logic [COORD_W-1:0]         out_row;
    logic [COORD_W-1:0]         out_col;
    logic                       last;

    frac_table u_frac_table (
        .CLK(CLK), .RST(RST),
        .build_start_i(build_start), .tw_i(tw_i),
        .frac_idx_i(frac_idx),
        .build_done_o(build_done), .frac_val_o(frac_val)
    );

    cubic_weight_gen u_weight_gen (
        .CLK(CLK), .RST(RST),
        .load_i(wload), .frac_i(frac_val),
        .weight0_o(weight[0]), .weight1_o(weight[1]),
        .weight2_o(weight[2]), .weight3_o(weight[3])
    );

    scale_sequencer u_sequencer (
        .CLK(CLK), .RST(RST),
        .v0_i(v0_i), .h0_i(h0_i), .sw_i(sw_i), .sh_i(sh_i), .tw_i(tw_i),
        .build_done_i(build_done), .build_start_o(build_start),
        .frac_idx_o(frac_idx), .wload_o(wload),
        .pix_rd_o(pix_rd_o), .pix_addr_o(pix_addr_o),
        .tap_sel_o(tap_sel), .pix_valid_o(pix_valid), .prod_go_o(prod_go),
        .out_row_o(out_row), .out_col_o(out_col), .last_o(last)
    );

    // one multiplier per window column
    for (genvar k = 0; k < NUM_TAPS; k++) begin : g_tap
        cubic_tap u_tap (
            .CLK(CLK), .RST(RST),
            .pix_valid_i(pix_valid), .sel_match_i(tap_sel == 2'(k)),
            .pix_i(pix_data_i), .weight_i(weight[k]),
            .go_i(prod_go), .prod_o(prod[k])
        );
    end

    tap_sum_clamp u_sum (
        .CLK(CLK), .RST(RST), .go_i(prod_go),
        .prod0_i(prod[0]), .prod1_i(prod[1]), .prod2_i(prod[2]), .prod3_i(prod[3]),
        .row_i(out_row), .col_i(out_col), .last_i(last),
        .res_we_o(res_we_o), .res_addr_o(res_addr_o), .res_data_o(res_data_o),
        .done_o(done_o)
    );

endmodule

/* verilog/tap_sum_clamp.sv */
module tap_sum_clamp
    import scaler_geom_pkg::*;
    import cubic_pkg::*;
(
    input  logic                     CLK,
    input  logic                     RST,
    input  logic                     go_i,
    input  logic signed [PROD_W-1:0] prod0_i,
    input  logic signed [PROD_W-1:0] prod1_i,
    input  logic signed [PROD_W-1:0] prod2_i,
    input  logic signed [PROD_W-1:0] prod3_i,
    input  logic [COORD_W-1:0]       row_i,
    input  logic [COORD_W-1:0]       col_i,
    input  logic                     last_i,
    output logic                     res_we_o,
    output logic [ADDR_W-1:0]        res_addr_o,
    output logic [PIX_W-1:0]         res_data_o,
    output logic                     done_o
);

    logic                     prod_vld;
    logic signed [PROD_W+1:0] sum_w;
    logic signed [PROD_W+1:0] shr_w;
    logic [PIX_W-1:0]         clamp_w;

    assign sum_w = prod0_i + prod1_i + prod2_i + prod3_i + (1 << (SUM_SHIFT - 1));
    assign shr_w = sum_w >>> SUM_SHIFT;

    always_comb begin
        if (shr_w < 0) begin
            clamp_w = '0;
        end else if (shr_w > (1 << PIX_W) - 1) begin
            clamp_w = '1;
        end else begin
            clamp_w = shr_w[PIX_W-1:0];
        end
    end

    // coordinates arrive already aligned with the write
    assign res_addr_o = ADDR_W'(row_i) * ADDR_W'(ROW_PITCH) + ADDR_W'(col_i);

    always_ff @(posedge CLK) begin
        if (RST) begin
            prod_vld <= 1'b0;
            res_we_o <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            prod_vld <= go_i;           // products settle one cycle after go
            res_we_o <= prod_vld;
            if (res_we_o && last_i) begin
                done_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (prod_vld) begin
            res_data_o <= clamp_w;
        end
    end

endmodule

/* verilog/cubic_tap.sv */
module cubic_tap
    import scaler_geom_pkg::*;
    import cubic_pkg::*;
(
    input  logic                       CLK,
    input  logic                       RST,
    input  logic                       pix_valid_i,
    input  logic                       sel_match_i,
    input  logic [PIX_W-1:0]           pix_i,
    input  logic signed [WEIGHT_W-1:0] weight_i,
    input  logic                       go_i,
    output logic signed [PROD_W-1:0]   prod_o
);

    logic [PIX_W-1:0]         pix_q;
    logic [PIX_W-1:0]         pix_sel;
    logic signed [PROD_W-1:0] mult_w;

    // last tap's pixel arrives in the go cycle, take it straight from the bus
    assign pix_sel = (pix_valid_i && sel_match_i) ? pix_i : pix_q;
    assign mult_w  = $signed({1'b0, pix_sel}) * weight_i;

    always_ff @(posedge CLK) begin
        if (pix_valid_i && sel_match_i) begin
            pix_q <= pix_i;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            prod_o <= '0;
        end else if (go_i) begin
            prod_o <= mult_w;
        end
    end

endmodule

/* verilog/scale_sequencer.sv */
module scale_sequencer
    import scaler_geom_pkg::*;
    import cubic_pkg::*;
(
    input  logic               CLK,
    input  logic               RST,
    input  logic [COORD_W-1:0] v0_i,
    input  logic [COORD_W-1:0] h0_i,
    input  logic [SW_W-1:0]    sw_i,
    input  logic [SW_W-1:0]    sh_i,
    input  logic [TW_W-1:0]    tw_i,
    input  logic               build_done_i,
    output logic               build_start_o,
    output logic [COORD_W-1:0] frac_idx_o,
    output logic               wload_o,
    output logic               pix_rd_o,
    output logic [ADDR_W-1:0]  pix_addr_o,
    output logic [1:0]         tap_sel_o,
    output logic               pix_valid_o,
    output logic               prod_go_o,
    output logic [COORD_W-1:0] out_row_o,
    output logic [COORD_W-1:0] out_col_o,
    output logic               last_o
);

    scaler_state_e state;

    logic [2:0]         slot_cnt;
    logic               started;
    logic [COORD_W-1:0] col_j;
    logic [COORD_W-1:0] quot;
    logic [COORD_W-1:0] rem;
    logic [COORD_W-1:0] row_y;
    logic [COORD_W-1:0] tw_m1;
    logic [COORD_W-1:0] sw_m1;
    logic [COORD_W-1:0] rem_sum;
    logic [COORD_W-1:0] rem_nxt;
    logic               carry;
    logic               slot_end;
    logic               row_end;
    logic               last_pix;
    logic [COORD_W-1:0] src_row;
    logic [COORD_W-1:0] src_col;
    logic [COORD_W-1:0] row_d1;
    logic [COORD_W-1:0] col_d1;
    logic               last_d1;

    assign tw_m1 = COORD_W'(tw_i - 1'b1);
    assign sw_m1 = COORD_W'(sw_i - 1'b1);

    // r steps by sw-1, at most one carry since sw <= tw
    assign rem_sum = rem + sw_m1;
    assign carry   = (rem_sum >= tw_m1);
    assign rem_nxt = row_end ? '0 : (carry ? rem_sum - tw_m1 : rem_sum);

    assign row_end  = (col_j == tw_m1);
    assign last_pix = row_end && (row_y == COORD_W'(sh_i - 1'b1));
    assign slot_end = (state == ST_RUN) && (slot_cnt == 3'(NUM_TAPS));

    assign build_start_o = (state == ST_BUILD) && !started;
    assign wload_o       = ((state == ST_BUILD) && build_done_i) || slot_end;
    assign frac_idx_o    = (state == ST_RUN) ? rem_nxt : rem;   // next slot's fraction
    assign prod_go_o     = slot_end;

    // taps at q-1 .. q+2 around the source position
    assign pix_rd_o   = (state == ST_RUN) && (slot_cnt < 3'(NUM_TAPS));
    assign src_row    = v0_i + row_y;
    assign src_col    = h0_i + quot + COORD_W'(slot_cnt) - 1'b1;
    assign pix_addr_o = ADDR_W'(src_row) * ADDR_W'(IMG_DIM) + ADDR_W'(src_col);

    always_ff @(posedge CLK) begin
        if (RST) begin
            state       <= ST_BUILD;
            started     <= 1'b0;
            slot_cnt    <= 3'd0;
            col_j       <= '0;
            quot        <= '0;
            rem         <= '0;
            row_y       <= '0;
            pix_valid_o <= 1'b0;
            last_d1     <= 1'b0;
            last_o      <= 1'b0;
        end else begin
            pix_valid_o <= pix_rd_o;    // read data returns next cycle
            last_o      <= last_d1;
            case (state)
                ST_BUILD: begin
                    started <= 1'b1;
                    if (build_done_i) begin
                        state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (slot_end) begin
                        slot_cnt <= 3'd0;
                        last_d1  <= last_pix;
                        rem      <= rem_nxt;
                        if (last_pix) begin
                            state <= ST_DONE;
                        end
                        if (row_end) begin
                            col_j <= '0;
                            quot  <= '0;
                            row_y <= row_y + 1'b1;
                        end else begin
                            col_j <= col_j + 1'b1;
                            quot  <= quot + COORD_W'(carry);
                        end
                    end else begin
                        slot_cnt <= slot_cnt + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // steering and coordinate delay line
    always_ff @(posedge CLK) begin
        tap_sel_o <= slot_cnt[1:0];
        if (slot_end) begin
            row_d1 <= row_y;
            col_d1 <= col_j;
        end
        out_row_o <= row_d1;
        out_col_o <= col_d1;
    end

endmodule

/* verilog/cubic_weight_gen.sv */
module cubic_weight_gen
    import cubic_pkg::*;
(
    input  logic                       CLK,
    input  logic                       RST,
    input  logic                       load_i,
    input  logic [FRAC_W-1:0]          frac_i,
    output logic signed [WEIGHT_W-1:0] weight0_o,
    output logic signed [WEIGHT_W-1:0] weight1_o,
    output logic signed [WEIGHT_W-1:0] weight2_o,
    output logic signed [WEIGHT_W-1:0] weight3_o
);

    logic [2*FRAC_W-1:0]        sq_w;
    logic [2*FRAC_W-1:0]        cube_w;
    logic [FRAC_W-1:0]          t2;
    logic [FRAC_W-1:0]          t3;
    logic signed [WEIGHT_W-1:0] t_s;
    logic signed [WEIGHT_W-1:0] t2_s;
    logic signed [WEIGHT_W-1:0] t3_s;
    logic signed [WEIGHT_W-1:0] w0, w1, w2, w3;

    // rounded powers, both stay below 256
    assign sq_w   = frac_i * frac_i + (1 << (FRAC_W - 1));
    assign t2     = sq_w[2*FRAC_W-1:FRAC_W];
    assign cube_w = t2 * frac_i + (1 << (FRAC_W - 1));
    assign t3     = cube_w[2*FRAC_W-1:FRAC_W];

    assign t_s  = WEIGHT_W'(frac_i);
    assign t2_s = WEIGHT_W'(t2);
    assign t3_s = WEIGHT_W'(t3);

    // Catmull-Rom, times two
    assign w0 = -t_s + 2 * t2_s - t3_s;
    assign w1 = (1 << SUM_SHIFT) - 5 * t2_s + 3 * t3_s;
    assign w2 = t_s + 4 * t2_s - 3 * t3_s;
    assign w3 = t3_s - t2_s;

    always_ff @(posedge CLK) begin
        if (RST) begin
            weight0_o <= '0;
            weight1_o <= '0;
            weight2_o <= '0;
            weight3_o <= '0;
        end else if (load_i) begin
            weight0_o <= w0;
            weight1_o <= w1;
            weight2_o <= w2;
            weight3_o <= w3;
        end
    end

endmodule

/* verilog/frac_table.sv */
module frac_table
    import scaler_geom_pkg::*;
    import cubic_pkg::*;
(
    input  logic               CLK,
    input  logic               RST,
    input  logic               build_start_i,
    input  logic [TW_W-1:0]    tw_i,
    input  logic [COORD_W-1:0] frac_idx_i,
    output logic               build_done_o,
    output logic [FRAC_W-1:0]  frac_val_o
);

    logic [FRAC_W-1:0] table_mem [FRAC_DEPTH];

    logic              busy;
    logic [2:0]        step;
    logic [TW_W-1:0]   entry;       // current r
    logic [TW_W-1:0]   divisor;
    logic [TW_W-1:0]   rem_q;
    logic [TW_W:0]     rem_sh;
    logic [TW_W:0]     rem_dif;
    logic              q_bit;
    logic [FRAC_W-1:0] quot_q;
    logic [FRAC_W-1:0] quot_nxt;
    logic              last_step;

    assign divisor   = tw_i - 1'b1;
    assign last_step = (step == 3'(FRAC_W - 1));

    // one restoring step, r < divisor so the remainder never overflows
    assign rem_sh   = {rem_q, 1'b0};
    assign q_bit    = (rem_sh >= {1'b0, divisor});
    assign rem_dif  = q_bit ? rem_sh - {1'b0, divisor} : rem_sh;
    assign quot_nxt = {quot_q[FRAC_W-2:0], q_bit};

    always_ff @(posedge CLK) begin
        if (RST) begin
            busy         <= 1'b0;
            step         <= 3'd0;
            entry        <= '0;
            build_done_o <= 1'b0;
        end else begin
            build_done_o <= 1'b0;
            if (build_start_i) begin
                busy  <= 1'b1;
                step  <= 3'd0;
                entry <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (last_step) begin
                    if (entry == divisor - 1'b1) begin
                        busy         <= 1'b0;
                        build_done_o <= 1'b1;
                    end else begin
                        entry <= entry + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (build_start_i) begin
            rem_q <= '0;
        end else if (busy) begin
            quot_q <= quot_nxt;
            if (last_step) begin
                table_mem[entry] <= quot_nxt;
                rem_q            <= entry + 1'b1;   // dividend of next entry
            end else begin
                rem_q <= rem_dif[TW_W-1:0];
            end
        end
    end

    assign frac_val_o = table_mem[frac_idx_i[TW_W-1:0]];

endmodule

/* verilog/cubic_pkg.sv */
package cubic_pkg;

    // fraction t in Q0.8
    localparam int FRAC_W = 8;

    // one tap per source column in the cubic window
    localparam int NUM_TAPS = 4;

    // weights are scaled by 512, products are pixel times weight
    localparam int WEIGHT_W  = 12;
    localparam int PROD_W    = 20;
    localparam int SUM_SHIFT = 9;

    // one table entry per output column fraction
    localparam int FRAC_DEPTH = 64;

    typedef enum logic [1:0] {
        ST_BUILD,   // fraction table fill
        ST_RUN,     // 5-cycle pixel slots
        ST_DONE
    } scaler_state_e;

endpackage

/* verilog/scaler_geom_pkg.sv */
package scaler_geom_pkg;

    // pixel and coordinate sizes
    localparam int PIX_W   = 8;
    localparam int COORD_W = 7;

    // source image is square, row-major
    localparam int IMG_DIM = 100;

    // image and result memories share one address width
    localparam int ADDR_W    = 14;
    localparam int ROW_PITCH = 128;   // result row stride

    // geometry input widths
    localparam int SW_W = 5;          // source width and height
    localparam int TW_W = 6;          // target width

endpackage
